/* Bender.yml */
package:
  name: agitate_stream

sources:
  - agitate_pkg.sv
  - agitate_gen.sv
  - stream_fifo.sv
  - agitate_cfg_regs.sv
  - agitate_stream_top.sv
  - target: test
    files:
      - tb_agitate_stream_top.sv

/* agitate_cfg_regs.sv */
module agitate_cfg_regs
  import agitate_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                        clk,
  input  logic                        rst_n,
  // write address and data
  input  logic [4:0]                  s_axi_awaddr,
  input  logic                        s_axi_awvalid,
  output logic                        s_axi_awready,
  input  logic [31:0]                 s_axi_wdata,
  input  logic                        s_axi_wvalid,
  output logic                        s_axi_wready,
  // write response
  output logic [1:0]                  s_axi_bresp,
  output logic                        s_axi_bvalid,
  input  logic                        s_axi_bready,
  // read address and data
  input  logic [4:0]                  s_axi_araddr,
  input  logic                        s_axi_arvalid,
  output logic                        s_axi_arready,
  output logic [31:0]                 s_axi_rdata,
  output logic [1:0]                  s_axi_rresp,
  output logic                        s_axi_rvalid,
  input  logic                        s_axi_rready,
  // agitator side
  output agitate_cfg_t                ctrl_in,
  output agitate_cfg_t                ctrl_out,
  input  logic                        agitate_in,
  input  logic                        agitate_out,
  input  logic [$clog2(FIFO_DEPTH):0] level
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam int         LEVEL_W     = $clog2(FIFO_DEPTH) + 1;

  agitate_reg_e wr_addr;
  agitate_reg_e rd_addr;
  logic         wr_en;
  logic         rd_en;
  logic         wr_ctrl_in;
  logic         wr_ctrl_out;
  logic [15:0]  count_in;
  logic [15:0]  count_out;
  logic [31:0]  rd_data;
  logic         rd_err;

  // ====================
  // write channel
  // ====================

  // address and data taken together, one outstanding response
  assign wr_en         = s_axi_awvalid & s_axi_wvalid & ~s_axi_bvalid;
  assign s_axi_awready = wr_en;
  assign s_axi_wready  = wr_en;
  assign wr_addr       = agitate_reg_e'(s_axi_awaddr);
  assign wr_ctrl_in    = wr_en && (wr_addr == reg_ctrl_in);
  assign wr_ctrl_out   = wr_en && (wr_addr == reg_ctrl_out);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_in      <= '0;
      ctrl_out     <= '0;
      s_axi_bvalid <= 1'b0;
    end else begin
      if (wr_ctrl_in) begin
        ctrl_in <= agitate_cfg_t'(s_axi_wdata);
      end
      if (wr_ctrl_out) begin
        ctrl_out <= agitate_cfg_t'(s_axi_wdata);
      end
      if (wr_en) begin
        s_axi_bvalid <= 1'b1;
      end else if (s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
    end
  end

  // read-only and unmapped targets both error out
  always_ff @(posedge clk) begin
    if (wr_en) begin
      s_axi_bresp <= (wr_ctrl_in || wr_ctrl_out) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // ====================
  // agitation counters
  // ====================

  // clear on control write wins over the increment
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_in  <= '0;
      count_out <= '0;
    end else begin
      if (wr_ctrl_in) begin
        count_in <= '0;
      end else if (agitate_in && count_in != 16'hffff) begin
        count_in <= count_in + 16'd1;
      end
      if (wr_ctrl_out) begin
        count_out <= '0;
      end else if (agitate_out && count_out != 16'hffff) begin
        count_out <= count_out + 16'd1;
      end
    end
  end

  // ====================
  // read channel
  // ====================

  assign rd_en         = s_axi_arvalid & ~s_axi_rvalid;
  assign s_axi_arready = rd_en;
  assign rd_addr       = agitate_reg_e'(s_axi_araddr);

  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (rd_addr)
      reg_ctrl_in:   rd_data = ctrl_in;
      reg_ctrl_out:  rd_data = ctrl_out;
      reg_status:    rd_data[LEVEL_W-1:0] = level;
      reg_count_in:  rd_data[15:0] = count_in;
      reg_count_out: rd_data[15:0] = count_out;
      default:       rd_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s_axi_rvalid <= 1'b0;
    end else if (rd_en) begin
      s_axi_rvalid <= 1'b1;
    end else if (s_axi_rready) begin
      s_axi_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      s_axi_rdata <= rd_data;
      s_axi_rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // response must wait for the master
  a_bvalid_hold : assert property (
    @(posedge clk) disable iff (!rst_n) (s_axi_bvalid && !s_axi_bready) |=> s_axi_bvalid
  );

endmodule

/* agitate_gen.sv */
module agitate_gen
  import agitate_pkg::*;
#(
  parameter logic [7:0] SEED          = 8'h01,
  parameter logic       AGITATE_VALUE = 1'b0
) (
  input  logic         clk,
  input  logic         rst_n,
  input  agitate_cfg_t control,
  input  logic         in_data,
  output logic         out_data,
  output logic         agitate
);

  // xor taps of the free running counter, one mask per random bit
  localparam logic [7:0][15:0] RAND_TAPS = {
    16'hA8E0, 16'h5470, 16'hAA38, 16'hD51C,
    16'h6A8E, 16'hB547, 16'hF243, 16'h51C1
  };

  agitate_cfg_t control_q;
  logic [15:0]  randcnt_q;
  logic [15:0]  randcnt_nxt;
  logic [7:0]   rand_q;
  logic [7:0]   rand_nxt;
  logic [15:0]  phase_q;
  logic [15:0]  phase_nxt;
  logic         agitate_q;
  logic         agitate_nxt;
  logic [15:0]  period_cycles;
  logic [15:0]  duty_point;
  logic [7:0]   prob_sel;

  // ====================
  // state
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      control_q <= '0;
      randcnt_q <= '0;
      rand_q    <= '0;
      phase_q   <= '0;
      agitate_q <= 1'b0;
    end else begin
      // mode always follows, the rest is kept across an off period
      if (control.mode != mode_off) begin
        control_q <= control;
      end else begin
        control_q.mode <= mode_off;
      end
      randcnt_q <= randcnt_nxt;
      rand_q    <= rand_nxt;
      phase_q   <= phase_nxt;
      agitate_q <= agitate_nxt;
    end
  end

  // ====================
  // next state
  // ====================

  // period field counts in 16 cycle units
  assign period_cycles = {1'b0, control_q.period, 4'd0};
  assign duty_point    = period_cycles >> control_q.duty;
  // first portion runs from phase 0 up to the duty point
  assign prob_sel      = (phase_q < duty_point) ? control_q.prob_1st : control_q.prob_2nd;

  always_comb begin
    randcnt_nxt = randcnt_q;
    rand_nxt    = rand_q;
    phase_nxt   = phase_q;
    agitate_nxt = 1'b0;

    // random byte only advances while enabled
    if (control_q.mode != mode_off) begin
      randcnt_nxt = randcnt_q + 16'd1;
      for (int i = 0; i < 8; i++) begin
        rand_nxt[i] = SEED[i] ^ (^(randcnt_q & RAND_TAPS[i]));
      end
    end

    if (control_q.mode == mode_period) begin
      // zero period wraps every cycle and stays in the second portion
      phase_nxt = phase_q + 16'd1;
      if (phase_nxt >= period_cycles) begin
        phase_nxt = '0;
      end
      // 255 is forced so that full scale means always
      agitate_nxt = (prob_sel == 8'hff) || (rand_q < prob_sel);
    end
  end

  // ====================
  // output
  // ====================

  always_comb begin
    out_data = in_data;
    if (agitate_q) begin
      out_data = AGITATE_VALUE;
    end
  end

  assign agitate = agitate_q;

  // flag may only trail the mode by the one registered cycle
  a_no_agitate_when_off : assert property (
    @(posedge clk) disable iff (!rst_n)
    (agitate_q && control_q.mode == mode_off) |-> $past(control_q.mode) == mode_period
  );

endmodule

/* agitate_pkg.sv */
package agitate_pkg;

  // ====================
  // agitator control
  // ====================

  // only mode 1 agitates, 2 and 3 are reserved
  typedef enum logic [1:0] {
    mode_off    = 2'd0,
    mode_period = 2'd1
  } agitate_mode_e;

  // one 32-bit control word, msb first
  typedef struct packed {
    // n/256 chance of agitating after the duty point
    logic [7:0]    prob_2nd;
    // n/256 chance of agitating before the duty point
    logic [7:0]    prob_1st;
    // period in units of 16 cycles
    logic [10:0]   period;
    // duty point = period >> duty
    logic [2:0]    duty;
    agitate_mode_e mode;
  } agitate_cfg_t;

  // ====================
  // stream beat
  // ====================

  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } stream_beat_t;

  // ====================
  // register map
  // ====================

  // byte addresses of the 32-bit registers
  typedef enum logic [4:0] {
    reg_ctrl_in   = 5'h00,
    reg_ctrl_out  = 5'h04,
    reg_status    = 5'h08,
    reg_count_in  = 5'h0C,
    reg_count_out = 5'h10
  } agitate_reg_e;

endpackage

/* agitate_stream_top.f */
agitate_pkg.sv
agitate_gen.sv
stream_fifo.sv
agitate_cfg_regs.sv
agitate_stream_top.sv
tb_agitate_stream_top.sv

/* agitate_stream_top.sv */
module agitate_stream_top
  import agitate_pkg::*;
#(
  parameter logic [7:0] SEED_IN    = 8'h5a,
  parameter logic [7:0] SEED_OUT   = 8'hc3,
  parameter int         FIFO_DEPTH = 8
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic [4:0]   s_axi_awaddr,
  input  logic         s_axi_awvalid,
  output logic         s_axi_awready,
  input  logic [31:0]  s_axi_wdata,
  input  logic         s_axi_wvalid,
  output logic         s_axi_wready,
  output logic [1:0]   s_axi_bresp,
  output logic         s_axi_bvalid,
  input  logic         s_axi_bready,
  input  logic [4:0]   s_axi_araddr,
  input  logic         s_axi_arvalid,
  output logic         s_axi_arready,
  output logic [31:0]  s_axi_rdata,
  output logic [1:0]   s_axi_rresp,
  output logic         s_axi_rvalid,
  input  logic         s_axi_rready,
  input  logic         s_valid,
  output logic         s_ready,
  input  stream_beat_t s_beat,
  output logic         m_valid,
  input  logic         m_ready,
  output stream_beat_t m_beat
);

  agitate_cfg_t                ctrl_in;
  agitate_cfg_t                ctrl_out;
  logic                        agitate_in;
  logic                        agitate_out;
  logic                        fifo_in_ready;
  logic                        fifo_out_valid;
  logic [$clog2(FIFO_DEPTH):0] level;

  // ====================
  // register block
  // ====================

  agitate_cfg_regs #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) cfg_regs_i (
    .clk, .rst_n,
    .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
    .s_axi_wdata, .s_axi_wvalid, .s_axi_wready,
    .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
    .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
    .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
    .ctrl_in, .ctrl_out, .agitate_in, .agitate_out, .level
  );

  // ====================
  // agitators
  // ====================

  // input back-pressure, forces s_ready low
  agitate_gen #(
    .SEED(SEED_IN), .AGITATE_VALUE(1'b0)
  ) agit_in (
    .clk, .rst_n, .control(ctrl_in),
    .in_data(fifo_in_ready), .out_data(s_ready), .agitate(agitate_in)
  );

  // output starvation, forces m_valid low
  agitate_gen #(
    .SEED(SEED_OUT), .AGITATE_VALUE(1'b0)
  ) agit_out (
    .clk, .rst_n, .control(ctrl_out),
    .in_data(fifo_out_valid), .out_data(m_valid), .agitate(agitate_out)
  );

  // ====================
  // fifo
  // ====================

  // handshakes qualified by the agitated signals seen outside
  stream_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) fifo_i (
    .clk, .rst_n,
    .in_valid(s_valid & s_ready), .in_ready(fifo_in_ready), .in_beat(s_beat),
    .out_valid(fifo_out_valid), .out_ready(m_ready & m_valid), .out_beat(m_beat),
    .level
  );

endmodule

/* stream_fifo.sv */
module stream_fifo
  import agitate_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        in_valid,
  output logic                        in_ready,
  input  stream_beat_t                in_beat,
  output logic                        out_valid,
  input  logic                        out_ready,
  output stream_beat_t                out_beat,
  output logic [$clog2(FIFO_DEPTH):0] level
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  stream_beat_t             mem [FIFO_DEPTH];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [PTR_W:0]           count;
  logic                     push;
  logic                     pop;

  // ====================
  // handshakes
  // ====================

  assign in_ready  = (count != FIFO_DEPTH[PTR_W:0]);
  assign out_valid = (count != '0);
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;

  // ====================
  // storage
  // ====================

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_beat;
    end
  end

  assign out_beat = mem[rd_ptr];

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  assign level = count;

  // upstream gating must already hold back pushes when full
  a_no_push_full : assert property (
    @(posedge clk) disable iff (!rst_n) in_valid |-> count != FIFO_DEPTH[PTR_W:0]
  );

  // downstream gating must already hold back pops when empty
  a_no_pop_empty : assert property (
    @(posedge clk) disable iff (!rst_n) out_ready |-> count != '0
  );

endmodule

/* tb_agitate_stream_top.sv */
module tb_agitate_stream_top
  import agitate_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int         MAX_CYCLES    = 20000;
  localparam int         ALWAYS_CYCLES = 300;
  localparam logic [1:0] RESP_OKAY     = 2'b00;
  localparam logic [1:0] RESP_SLVERR   = 2'b10;

  logic         clk;
  logic         rst_n;
  logic [4:0]   s_axi_awaddr;
  logic         s_axi_awvalid;
  logic         s_axi_awready;
  logic [31:0]  s_axi_wdata;
  logic         s_axi_wvalid;
  logic         s_axi_wready;
  logic [1:0]   s_axi_bresp;
  logic         s_axi_bvalid;
  logic         s_axi_bready;
  logic [4:0]   s_axi_araddr;
  logic         s_axi_arvalid;
  logic         s_axi_arready;
  logic [31:0]  s_axi_rdata;
  logic [1:0]   s_axi_rresp;
  logic         s_axi_rvalid;
  logic         s_axi_rready;
  logic         s_valid;
  logic         s_ready;
  stream_beat_t s_beat;
  logic         m_valid;
  logic         m_ready;
  stream_beat_t m_beat;

  // scoreboard and phase control
  stream_beat_t sb_q[$];
  stream_beat_t exp_head;
  logic         exp_empty;
  logic         in_taken;
  logic         src_en;
  logic         sink_random;
  logic         check_passthru;
  logic         check_always;
  logic [31:0]  rd_lo;
  logic [31:0]  rd_hi;
  logic [1:0]   rd_resp_exp;
  logic [1:0]   wr_resp_exp;
  agitate_cfg_t cfg_in_mix;
  agitate_cfg_t cfg_out_mix;
  int           errors;
  int           cycles;
  int           beats;

  agitate_stream_top agitate_stream_top_i (.*);

  always #5 clk = ~clk;

  // ====================
  // run limit
  // ====================

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ====================
  // stream side
  // ====================

  // reference queue, head and empty flag are what the next edge checks against
  always @(posedge clk) begin
    if (!rst_n) begin
      sb_q.delete();
      in_taken = 1'b0;
    end else begin
      if (m_valid && m_ready && sb_q.size() != 0) begin
        void'(sb_q.pop_front());
        beats++;
      end
      in_taken = s_valid && s_ready;
      if (in_taken) begin
        sb_q.push_back(s_beat);
      end
    end
    exp_empty = (sb_q.size() == 0);
    exp_head  = exp_empty ? '0 : sb_q[0];
  end

  // source holds a beat until taken, sink ready is random only when asked
  initial begin
    void'($urandom(32'hdf6a_f986));
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        s_valid <= 1'b0;
      end else if (!s_valid || in_taken) begin
        if (src_en && $urandom_range(3, 0) != 0) begin
          s_valid     <= 1'b1;
          s_beat.data <= 8'($urandom);
          s_beat.last <= ($urandom_range(7, 0) == 0);
        end else begin
          s_valid <= 1'b0;
        end
      end
      m_ready <= sink_random ? 1'($urandom_range(1, 0)) : 1'b1;
    end
  end

  // ====================
  // checks
  // ====================

  a_order : assert property (@(posedge clk) disable iff (!rst_n)
    (m_valid && m_ready) |-> (!exp_empty && m_beat == exp_head))
  else begin
    errors++;
    $display("mismatch at %0t: output beat %h, expected %h (queue empty %0b)",
             $time, $sampled(m_beat), $sampled(exp_head), $sampled(exp_empty));
  end

  // no agitation, so ready never drops and valid tracks the queue
  a_passthru : assert property (@(posedge clk) disable iff (!rst_n)
    check_passthru |-> (s_ready && m_valid == !exp_empty))
  else begin
    errors++;
    $display("mismatch at %0t: s_ready %0b m_valid %0b with queue empty %0b",
             $time, $sampled(s_ready), $sampled(m_valid), $sampled(exp_empty));
  end

  a_always_stall : assert property (@(posedge clk) disable iff (!rst_n)
    check_always |-> !s_ready)
  else begin
    errors++;
    $display("mismatch at %0t: s_ready high under full input agitation", $time);
  end

  // address and data ready pulse together, only in the cycle that takes the write
  a_write_ready : assert property (@(posedge clk) disable iff (!rst_n)
    (s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid) ? (s_axi_awready && s_axi_wready)
                                                      : !(s_axi_awready || s_axi_wready))
  else begin
    errors++;
    $display("mismatch at %0t: awready %0b wready %0b with bvalid %0b", $time,
             $sampled(s_axi_awready), $sampled(s_axi_wready), $sampled(s_axi_bvalid));
  end

  a_read_ready : assert property (@(posedge clk) disable iff (!rst_n)
    s_axi_arready == (s_axi_arvalid && !s_axi_rvalid))
  else begin
    errors++;
    $display("mismatch at %0t: arready %0b with arvalid %0b rvalid %0b", $time,
             $sampled(s_axi_arready), $sampled(s_axi_arvalid), $sampled(s_axi_rvalid));
  end

  a_read_value : assert property (@(posedge clk) disable iff (!rst_n)
    (s_axi_rvalid && s_axi_rready) |->
      (s_axi_rresp == rd_resp_exp && s_axi_rdata >= rd_lo && s_axi_rdata <= rd_hi))
  else begin
    errors++;
    $display("mismatch at %0t: read %h resp %0d, expected %h..%h resp %0d", $time,
             $sampled(s_axi_rdata), $sampled(s_axi_rresp), rd_lo, rd_hi, rd_resp_exp);
  end

  a_write_resp : assert property (@(posedge clk) disable iff (!rst_n)
    (s_axi_bvalid && s_axi_bready) |-> s_axi_bresp == wr_resp_exp)
  else begin
    errors++;
    $display("mismatch at %0t: write resp %0d, expected %0d",
             $time, $sampled(s_axi_bresp), wr_resp_exp);
  end

  // ====================
  // bus tasks
  // ====================

  function automatic agitate_cfg_t make_cfg(input logic [7:0] p2, input logic [7:0] p1,
                                            input logic [10:0] period, input logic [2:0] duty,
                                            input agitate_mode_e mode);
    agitate_cfg_t cfg;
    cfg.prob_2nd = p2;
    cfg.prob_1st = p1;
    cfg.period   = period;
    cfg.duty     = duty;
    cfg.mode     = mode;
    return cfg;
  endfunction

  // returns one negedge after bready is taken
  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data,
                           input logic [1:0] resp);
    @(negedge clk);
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    wr_resp_exp   = resp;
    // bvalid rises on the edge that takes the write
    @(negedge clk);
    while (!s_axi_bvalid) @(negedge clk);
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b1;
    @(negedge clk);
    s_axi_bready = 1'b0;
  endtask

  task automatic read_check(input logic [4:0] addr, input logic [31:0] lo,
                            input logic [31:0] hi, input logic [1:0] resp);
    @(negedge clk);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    @(negedge clk);
    while (!s_axi_rvalid) @(negedge clk);
    s_axi_arvalid = 1'b0;
    rd_lo         = lo;
    rd_hi         = hi;
    rd_resp_exp   = resp;
    s_axi_rready  = 1'b1;
    @(negedge clk);
    s_axi_rready = 1'b0;
  endtask

  // ====================
  // sequence
  // ====================

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    s_axi_awaddr   = '0;
    s_axi_awvalid  = 1'b0;
    s_axi_wdata    = '0;
    s_axi_wvalid   = 1'b0;
    s_axi_bready   = 1'b0;
    s_axi_araddr   = '0;
    s_axi_arvalid  = 1'b0;
    s_axi_rready   = 1'b0;
    s_valid        = 1'b0;
    s_beat         = '0;
    m_ready        = 1'b1;
    src_en         = 1'b0;
    sink_random    = 1'b0;
    check_passthru = 1'b0;
    check_always   = 1'b0;
    rd_lo          = '0;
    rd_hi          = '0;
    rd_resp_exp    = RESP_OKAY;
    wr_resp_exp    = RESP_OKAY;
    cfg_in_mix     = make_cfg(8'h20, 8'h60, 11'd4, 3'd1, mode_period);
    cfg_out_mix    = make_cfg(8'ha0, 8'h30, 11'd2, 3'd2, mode_period);
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // both agitators off, sink always ready
    src_en         = 1'b1;
    check_passthru = 1'b1;
    repeat (200) @(negedge clk);

    // enabled but zero probability behaves as off
    check_passthru = 1'b0;
    write_reg(reg_ctrl_in, make_cfg(8'h00, 8'h00, 11'd4, 3'd1, mode_period), RESP_OKAY);
    write_reg(reg_ctrl_out, make_cfg(8'h00, 8'h00, 11'd3, 3'd2, mode_period), RESP_OKAY);
    check_passthru = 1'b1;
    repeat (200) @(negedge clk);
    check_passthru = 1'b0;
    read_check(reg_count_in, 32'd0, 32'd0, RESP_OKAY);
    read_check(reg_count_out, 32'd0, 32'd0, RESP_OKAY);

    // full scale input agitation, flag lands two edges after the response
    sink_random = 1'b1;
    write_reg(reg_ctrl_in, make_cfg(8'hff, 8'hff, 11'd2, 3'd1, mode_period), RESP_OKAY);
    @(negedge clk);
    check_always = 1'b1;
    repeat (ALWAYS_CYCLES) @(negedge clk);
    // count tracks the stalled run within the pipeline slack
    read_check(reg_count_in, ALWAYS_CYCLES - 2, ALWAYS_CYCLES + 2, RESP_OKAY);
    check_always = 1'b0;
    write_reg(reg_ctrl_in, make_cfg(8'hff, 8'hff, 11'd2, 3'd1, mode_off), RESP_OKAY);
    read_check(reg_count_in, 32'd0, 32'd2, RESP_OKAY);

    // both sides agitating at random with a random sink
    write_reg(reg_ctrl_in, cfg_in_mix, RESP_OKAY);
    write_reg(reg_ctrl_out, cfg_out_mix, RESP_OKAY);
    repeat (4000) @(negedge clk);

    // drain, then register map checks on a quiet stream
    src_en = 1'b0;
    while (s_valid || sb_q.size() != 0) @(negedge clk);
    read_check(reg_ctrl_in, cfg_in_mix, cfg_in_mix, RESP_OKAY);
    read_check(reg_ctrl_out, cfg_out_mix, cfg_out_mix, RESP_OKAY);
    read_check(5'h14, 32'd0, 32'hffff_ffff, RESP_SLVERR);
    write_reg(reg_status, 32'h0000_00ff, RESP_SLVERR);
    write_reg(5'h14, 32'hffff_ffff, RESP_SLVERR);
    read_check(reg_status, 32'd0, 32'd0, RESP_OKAY);
    read_check(reg_ctrl_in, cfg_in_mix, cfg_in_mix, RESP_OKAY);
    read_check(reg_ctrl_out, cfg_out_mix, cfg_out_mix, RESP_OKAY);

    write_reg(reg_ctrl_in, 32'd0, RESP_OKAY);
    write_reg(reg_ctrl_out, 32'd0, RESP_OKAY);
    a_drained : assert (sb_q.size() == 0 && beats > 0) else begin
      errors++;
      $display("stream check failed: %0d beats left over, %0d beats delivered",
               sb_q.size(), beats);
    end

    $display("checks done: %0d errors, %0d beats, %0d cycles", errors, beats, cycles);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
